// ==== rtl/dbf_pkg.sv ====
// --------------------------------------------------
// dynamic bloom filter shared widths and types
// --------------------------------------------------
package dbf_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	localparam int KEY_W        = 32;                      // lookup key width
	localparam int VAL_W        = 8;                       // value and bank byte width
	localparam int BANK_ADDR_W  = 10;                      // bank byte address width
	localparam int BANK_DEPTH   = 1 << BANK_ADDR_W;        // 1024 bytes per bank
	localparam int NUM_BANKS    = 3;                       // hash banks
	localparam int BUS_ADDR_W   = 22;                      // local bus address width
	localparam int BANK_SEL_LSB = 20;                      // low bit of bank select field

	// --------------------------------------------------
	// vector types
	// --------------------------------------------------
	typedef logic [KEY_W-1:0]       key_t;                 // incoming key
	typedef logic [VAL_W-1:0]       value_t;               // bank byte / result
	typedef logic [BANK_ADDR_W-1:0] bank_addr_t;           // byte address in a bank
	typedef logic [BUS_ADDR_W-1:0]  bus_addr_t;            // host bus address

	// one port request into a bank, 20 bits
	typedef struct packed {
		logic       rd_en;                                 // registered read
		logic       wr_en;                                 // byte write
		bank_addr_t addr;                                  // byte address
		value_t     wdata;                                 // write byte
	} bank_port_t;

endpackage

// ==== rtl/key_fifo.sv ====
// --------------------------------------------------
// key FIFO, synchronous and show-ahead
// head key is valid whenever empty is low
// --------------------------------------------------
`timescale 1ns/1ps

module key_fifo #(
	parameter int KEY_FIFO_DEPTH = 16,                     // entries
	parameter int KEY_ALF_LEVEL  = 15                      // almost-full threshold
) (
	input  logic           Clk,                            // core clock
	input  logic           Reset_N,                        // async reset, active low
	input  logic           wr,                             // push strobe
	input  dbf_pkg::key_t  wdata,                          // key to push
	input  logic           rd,                             // pop, head consumed this cycle
	output dbf_pkg::key_t  rdata,                          // head key
	output logic           empty,                          // no key stored
	output logic           alf                             // almost full
);

	localparam int PTR_W = $clog2(KEY_FIFO_DEPTH);         // pointer width
	localparam int CNT_W = $clog2(KEY_FIFO_DEPTH + 1);     // occupancy width

	dbf_pkg::key_t    mem [KEY_FIFO_DEPTH];                // key storage
	logic [PTR_W-1:0] wr_ptr;                              // next slot to write
	logic [PTR_W-1:0] rd_ptr;                              // head slot
	logic [CNT_W-1:0] count;                               // keys held
	logic             full;                                // no free slot
	logic             do_wr;                               // accepted push
	logic             do_rd;                               // accepted pop

	assign full  = (count == CNT_W'(KEY_FIFO_DEPTH));      // all slots used
	assign empty = (count == '0);                          // nothing to pop
	assign alf   = (count >= CNT_W'(KEY_ALF_LEVEL));       // backpressure level
	assign do_wr = wr & ~full;                             // drop on overflow
	assign do_rd = rd & ~empty;                            // ignore underflow
	assign rdata = mem[rd_ptr];                            // show-ahead head

	// storage, no reset
	always_ff @(posedge Clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wdata;                          // store key
		end
	end

	// --------------------------------------------------
	// pointers and occupancy
	// --------------------------------------------------
	always_ff @(posedge Clk or negedge Reset_N) begin
		if (!Reset_N) begin
			wr_ptr <= '0;                                  // empty buffer
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_W'(KEY_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_W'(KEY_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;            // push only
				2'b01:   count <= count - 1'b1;            // pop only
				default: count <= count;                   // both or none
			endcase
		end
	end

	// a write into a full FIFO loses a key
	a_no_overflow: assert property (@(posedge Clk) disable iff (!Reset_N)
		!(wr && full))
		else $error("key FIFO written while full");

	// the engine must only pop a presented key
	a_no_underflow: assert property (@(posedge Clk) disable iff (!Reset_N)
		!(rd && empty))
		else $error("key FIFO read while empty");

endmodule

// ==== rtl/lookup_engine.sv ====
// --------------------------------------------------
// lookup engine, pops keys and reads three banks
// value = XOR of the three bank bytes
// --------------------------------------------------
`timescale 1ns/1ps

module lookup_engine (
	input  logic                Clk,                       // core clock
	input  logic                Reset_N,                   // async reset, active low
	input  dbf_pkg::key_t       key,                       // FIFO head
	input  logic                key_empty,                 // FIFO empty
	input  logic                value_alf,                 // downstream almost full
	input  dbf_pkg::value_t     bank_q   [dbf_pkg::NUM_BANKS], // port A read data
	output logic                key_rd,                    // pop head key
	output dbf_pkg::bank_port_t bank_req [dbf_pkg::NUM_BANKS], // port A requests
	output dbf_pkg::value_t     value,                     // lookup result
	output logic                value_wr                   // result strobe
);

	logic [1:0]      in_flight;                            // [0] request sent, [1] data back
	dbf_pkg::value_t hash_x;                               // combined bank bytes

	// pop whenever a key waits and downstream has room
	assign key_rd = ~key_empty & ~value_alf;

	always_comb begin
		hash_x = '0;
		for (int i = 0; i < dbf_pkg::NUM_BANKS; i++) begin
			hash_x = hash_x ^ bank_q[i];                   // fold each bank in
		end
	end

	// --------------------------------------------------
	// request stage and in-flight tracking
	// --------------------------------------------------
	always_ff @(posedge Clk or negedge Reset_N) begin
		if (!Reset_N) begin
			in_flight <= '0;                               // nothing issued
			value_wr  <= 1'b0;
			for (int i = 0; i < dbf_pkg::NUM_BANKS; i++) begin
				bank_req[i] <= '0;                         // all enables low
			end
		end else begin
			in_flight <= {in_flight[0], key_rd};           // two-deep shift
			value_wr  <= in_flight[1];                     // strobe as data lands
			for (int i = 0; i < dbf_pkg::NUM_BANKS; i++) begin
				bank_req[i].rd_en <= key_rd;               // read only on pop
				bank_req[i].wr_en <= 1'b0;                 // lookups never write
				bank_req[i].wdata <= '0;
				if (key_rd) begin
					// disjoint 10-bit slice per bank
					bank_req[i].addr <= key[i*dbf_pkg::BANK_ADDR_W +: dbf_pkg::BANK_ADDR_W];
				end
			end
		end
	end

	// XOR result register
	always_ff @(posedge Clk) begin
		if (in_flight[1]) begin
			value <= hash_x;                               // latch XOR result
		end
	end

	// a completing lookup only combines loaded table bytes
	a_value_known: assert property (@(posedge Clk) disable iff (!Reset_N)
		in_flight[1] |-> !$isunknown(hash_x))
		else $error("lookup combined an unloaded bank byte");

endmodule

// ==== rtl/host_bus_ctrl.sv ====
// --------------------------------------------------
// local bus controller for host bank access
// write acks after 2 cycles, read after 3
// --------------------------------------------------
`timescale 1ns/1ps

module host_bus_ctrl (
	input  logic                Clk,                       // core clock
	input  logic                Reset_N,                   // async reset, active low
	input  logic                cs_n,                      // chip select, active low
	input  logic                rw,                        // 1 write, 0 read
	input  dbf_pkg::bus_addr_t  addr,                      // bank select + byte address
	input  dbf_pkg::value_t     wdata,                     // write byte
	input  dbf_pkg::value_t     bank_q   [dbf_pkg::NUM_BANKS], // port B read data
	output dbf_pkg::bank_port_t bank_req [dbf_pkg::NUM_BANKS], // port B requests
	output dbf_pkg::value_t     rdata,                     // read byte
	output logic                ack_n                      // done, active low
);

	localparam int SEL_W = dbf_pkg::BUS_ADDR_W - dbf_pkg::BANK_SEL_LSB; // 2-bit select

	typedef enum logic [2:0] {
		st_idle,                                           // wait for cs_n low
		st_write,                                          // issue bank write
		st_read,                                           // issue bank read
		st_wait,                                           // bank access cycle
		st_capture,                                        // take read byte
		st_release                                         // hold ack until cs_n high
	} state_t;

	state_t                   state;                       // FSM state
	logic                     op_wr;                       // current access is a write
	logic [SEL_W-1:0]         sel_raw;                     // select field from addr
	logic [SEL_W-1:0]         bank_idx;                    // decoded bank
	logic [SEL_W-1:0]         sel_q;                       // bank of pending read

	assign sel_raw  = addr[dbf_pkg::BANK_SEL_LSB +: SEL_W];
	assign bank_idx = (sel_raw == 2'd3) ? 2'd0 : sel_raw;  // select 3 aliases bank 0

	// --------------------------------------------------
	// bus FSM
	// --------------------------------------------------
	always_ff @(posedge Clk or negedge Reset_N) begin
		if (!Reset_N) begin
			state <= st_idle;
			op_wr <= 1'b0;
			sel_q <= '0;
			rdata <= '0;                                   // read data cleared
			ack_n <= 1'b1;                                 // no ack
			for (int i = 0; i < dbf_pkg::NUM_BANKS; i++) begin
				bank_req[i] <= '0;                         // enables low
			end
		end else begin
			case (state)
				st_idle: begin
					if (!cs_n) begin
						op_wr <= rw;                       // remember direction
						state <= rw ? st_write : st_read;
					end
				end
				st_write: begin
					for (int i = 0; i < dbf_pkg::NUM_BANKS; i++) begin
						bank_req[i].wr_en <= (bank_idx == SEL_W'(i)); // one bank only
						bank_req[i].addr  <= addr[dbf_pkg::BANK_ADDR_W-1:0];
						bank_req[i].wdata <= wdata;
					end
					state <= st_wait;
				end
				st_read: begin
					sel_q <= bank_idx;                     // pick returning byte later
					for (int i = 0; i < dbf_pkg::NUM_BANKS; i++) begin
						bank_req[i].rd_en <= (bank_idx == SEL_W'(i));
						bank_req[i].addr  <= addr[dbf_pkg::BANK_ADDR_W-1:0];
					end
					state <= st_wait;
				end
				st_wait: begin
					for (int i = 0; i < dbf_pkg::NUM_BANKS; i++) begin
						bank_req[i].rd_en <= 1'b0;         // single-cycle request
						bank_req[i].wr_en <= 1'b0;
					end
					if (op_wr) begin
						ack_n <= 1'b0;                     // byte written this edge
						state <= st_release;
					end else begin
						state <= st_capture;               // q_b valid next
					end
				end
				st_capture: begin
					for (int i = 0; i < dbf_pkg::NUM_BANKS; i++) begin
						if (sel_q == SEL_W'(i)) begin
							rdata <= bank_q[i];            // selected bank byte
						end
					end
					ack_n <= 1'b0;                         // rdata valid with ack
					state <= st_release;
				end
				st_release: begin
					if (cs_n) begin
						ack_n <= 1'b1;                     // host let go
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// host keeps cs_n low and addr steady until the ack
	a_bus_held: assert property (@(posedge Clk) disable iff (!Reset_N)
		(state inside {st_write, st_read, st_wait, st_capture}) |-> (!cs_n && $stable(addr)))
		else $error("host changed the bus before ack");

endmodule

// ==== rtl/hash_bank.sv ====
// --------------------------------------------------
// hash bank, 1024 x 8 true dual port
// port A for lookups, port B for the host
// --------------------------------------------------
`timescale 1ns/1ps

module hash_bank (
	input  logic                Clk,                       // core clock
	input  logic                Reset_N,                   // async reset, active low
	input  dbf_pkg::bank_port_t port_a,                    // lookup port
	input  dbf_pkg::bank_port_t port_b,                    // host port
	output dbf_pkg::value_t     q_a,                       // port A read byte
	output dbf_pkg::value_t     q_b                        // port B read byte
);

	dbf_pkg::value_t mem [dbf_pkg::BANK_DEPTH];            // table bytes

	// writes from either port
	always_ff @(posedge Clk) begin
		if (port_a.wr_en) begin
			mem[port_a.addr] <= port_a.wdata;
		end
		if (port_b.wr_en) begin
			mem[port_b.addr] <= port_b.wdata;
		end
	end

	// --------------------------------------------------
	// registered reads, old byte on collision
	// --------------------------------------------------
	always_ff @(posedge Clk or negedge Reset_N) begin
		if (!Reset_N) begin
			q_a <= '0;
			q_b <= '0;
		end else begin
			if (port_a.rd_en) begin
				q_a <= mem[port_a.addr];                   // one cycle latency
			end
			if (port_b.rd_en) begin
				q_b <= mem[port_b.addr];
			end
		end
	end

	// lookup and host writes to one byte would race
	a_no_dual_write: assert property (@(posedge Clk) disable iff (!Reset_N)
		!(port_a.wr_en && port_b.wr_en && (port_a.addr == port_b.addr)))
		else $error("both bank ports write the same address");

endmodule

// ==== rtl/dynamic_bloom_filter.sv ====
// --------------------------------------------------
// dynamic bloom filter top, key FIFO + lookup
// engine + host bus controller over three banks
// --------------------------------------------------
`timescale 1ns/1ps

module dynamic_bloom_filter #(
	parameter int KEY_FIFO_DEPTH = 16,                     // key FIFO entries
	parameter int KEY_ALF_LEVEL  = 15                      // key almost-full level
) (
	input  logic               Clk,                        // core clock
	input  logic               Reset_N,                    // async reset, active low
	input  dbf_pkg::key_t      key,                        // incoming key
	input  logic               key_wr,                     // key strobe
	input  logic               value_alf,                  // downstream almost full
	input  logic               cs_n,                       // bus chip select
	input  logic               rw,                         // bus direction
	input  dbf_pkg::bus_addr_t addr,                       // bus address
	input  dbf_pkg::value_t    wdata,                      // bus write byte
	output logic               key_alf,                    // key FIFO almost full
	output dbf_pkg::value_t    value,                      // lookup result
	output logic               value_wr,                   // result strobe
	output dbf_pkg::value_t    rdata,                      // bus read byte
	output logic               ack_n                       // bus ack, active low
);

	dbf_pkg::key_t       head_key;                         // FIFO head
	logic                key_empty;                        // FIFO empty
	logic                key_rd;                           // FIFO pop
	dbf_pkg::bank_port_t eng_req  [dbf_pkg::NUM_BANKS];    // port A requests
	dbf_pkg::bank_port_t host_req [dbf_pkg::NUM_BANKS];    // port B requests
	dbf_pkg::value_t     eng_q    [dbf_pkg::NUM_BANKS];    // port A data
	dbf_pkg::value_t     host_q   [dbf_pkg::NUM_BANKS];    // port B data

	key_fifo #(
		.KEY_FIFO_DEPTH (KEY_FIFO_DEPTH),
		.KEY_ALF_LEVEL  (KEY_ALF_LEVEL)
	) u_key_fifo (
		.Clk     (Clk),
		.Reset_N (Reset_N),
		.wr      (key_wr),
		.wdata   (key),
		.rd      (key_rd),
		.rdata   (head_key),
		.empty   (key_empty),
		.alf     (key_alf)
	);

	lookup_engine u_lookup_engine (
		.Clk       (Clk),
		.Reset_N   (Reset_N),
		.key       (head_key),
		.key_empty (key_empty),
		.value_alf (value_alf),
		.bank_q    (eng_q),
		.key_rd    (key_rd),
		.bank_req  (eng_req),
		.value     (value),
		.value_wr  (value_wr)
	);

	host_bus_ctrl u_host_bus_ctrl (
		.Clk      (Clk),
		.Reset_N  (Reset_N),
		.cs_n     (cs_n),
		.rw       (rw),
		.addr     (addr),
		.wdata    (wdata),
		.bank_q   (host_q),
		.bank_req (host_req),
		.rdata    (rdata),
		.ack_n    (ack_n)
	);

	// one bank per key slice
	for (genvar i = 0; i < dbf_pkg::NUM_BANKS; i++) begin : g_bank
		hash_bank u_hash_bank (
			.Clk     (Clk),
			.Reset_N (Reset_N),
			.port_a  (eng_req[i]),
			.port_b  (host_req[i]),
			.q_a     (eng_q[i]),
			.q_b     (host_q[i])
		);
	end

endmodule

// ==== dv/dbf_tb.sv ====
// --------------------------------------------------
// dynamic bloom filter testbench, host table load,
// readback, key stream and downstream backpressure
// --------------------------------------------------
`timescale 1ns/1ps

module dbf_tb;

	localparam int CLK_PERIOD   = 100;                     // ns
	localparam int RESET_CYCLES = 4;
	localparam int NUM_FILL     = dbf_pkg::NUM_BANKS * dbf_pkg::BANK_DEPTH; // every bank byte
	localparam int NUM_RAND     = 64;                      // random host writes
	localparam int NUM_STREAM   = 200;                     // free-running keys
	localparam int NUM_STALL    = 40;                      // keys around the value_alf pulse
	localparam int NUM_LEVEL    = 15;                      // keys to reach key_alf
	localparam int WR_ACK_LAT   = 4;                       // negedges from drive, ack 2 cycles after sample
	localparam int RD_ACK_LAT   = 5;                       // ack 3 cycles after sample
	localparam int ACK_TIMEOUT  = 20;                      // cycles
	localparam int DRAIN_LIMIT  = 100;                     // cycles
	localparam int NUM_OPS      = NUM_FILL + 2 * NUM_RAND + 2;
	localparam int NUM_KEYS     = NUM_STREAM + NUM_STALL + NUM_LEVEL;
	localparam int WATCHDOG_CYCLES = (NUM_OPS + NUM_KEYS) * 20 + 1000;

	logic               Clk;
	logic               Reset_N;
	dbf_pkg::key_t      key;
	logic               key_wr;
	logic               value_alf;
	logic               cs_n;
	logic               rw;
	dbf_pkg::bus_addr_t addr;
	dbf_pkg::value_t    wdata;
	logic               key_alf;
	dbf_pkg::value_t    value;
	logic               value_wr;
	dbf_pkg::value_t    rdata;
	logic               ack_n;

	dbf_pkg::value_t    model [dbf_pkg::NUM_BANKS][dbf_pkg::BANK_DEPTH]; // bank mirror
	dbf_pkg::value_t    exp_q [$];                         // expected values, key order
	dbf_pkg::bus_addr_t rand_addr_q [$];                   // addresses of random writes
	integer             seed;
	string              test_name;
	int                 stall_strobes;                     // strobes during one stall
	logic               alf_seen;                          // value_alf at last negedge

	dynamic_bloom_filter uut (
		.Clk       (Clk),
		.Reset_N   (Reset_N),
		.key       (key),
		.key_wr    (key_wr),
		.value_alf (value_alf),
		.cs_n      (cs_n),
		.rw        (rw),
		.addr      (addr),
		.wdata     (wdata),
		.key_alf   (key_alf),
		.value     (value),
		.value_wr  (value_wr),
		.rdata     (rdata),
		.ack_n     (ack_n)
	);

	initial Clk = 1'b0;
	always #(CLK_PERIOD / 2) Clk = ~Clk;                   // 100 ns period

	// --------------------------------------------------
	// reporting and compares
	// --------------------------------------------------
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input dbf_pkg::value_t exp,
		input dbf_pkg::value_t act);
		if (act !== exp) begin
			report_failure($sformatf("[FAIL] %s: expected 0x%02h, actual 0x%02h", name, exp, act));
		end
	endtask

	task automatic check_rdata(input string name, input dbf_pkg::value_t exp,
		input dbf_pkg::value_t act);
		if (act !== exp) begin
			report_failure($sformatf("[FAIL] %s: expected 0x%02h, actual 0x%02h", name, exp, act));
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			report_failure($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	task automatic match_latency(input string name, input int exp, input int act);
		if (act != exp) begin
			report_failure($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
		end
	endtask

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic int bank_of(input dbf_pkg::bus_addr_t a);
		logic [1:0] sel;
		sel = a[dbf_pkg::BANK_SEL_LSB +: 2];
		return (sel == 2'd3) ? 0 : int'(sel);              // select 3 lands in bank 0
	endfunction

	function automatic dbf_pkg::value_t ref_value(input dbf_pkg::key_t k);
		return model[0][k[9:0]] ^ model[1][k[19:10]] ^ model[2][k[29:20]];
	endfunction

	// --------------------------------------------------
	// local bus host
	// --------------------------------------------------
	task automatic wait_ack(output int lat);
		logic got;
		lat = 0;
		got = 1'b0;
		while (!got) begin
			@(negedge Clk);
			lat++;
			got = (ack_n === 1'b0);
			if (!got && lat >= ACK_TIMEOUT) begin
				report_failure("host bus controller never drove ack_n low");
			end
		end
	endtask

	task automatic release_bus();
		int cycles;
		@(negedge Clk);
		check_level({test_name, " ack_n held"}, 1'b0, ack_n); // cs_n still low
		@(posedge Clk);
		cs_n <= 1'b1;
		cycles = 0;
		while (ack_n !== 1'b1) begin
			@(negedge Clk);
			cycles++;
			if (cycles > ACK_TIMEOUT) begin
				report_failure("ack_n stayed low after cs_n was released");
			end
		end
	endtask

	task automatic host_write(input dbf_pkg::bus_addr_t a, input dbf_pkg::value_t d);
		int lat;
		@(posedge Clk);
		cs_n  <= 1'b0;
		rw    <= 1'b1;
		addr  <= a;
		wdata <= d;
		wait_ack(lat);
		match_latency({test_name, " write ack latency"}, WR_ACK_LAT, lat);
		release_bus();
		model[bank_of(a)][a[9:0]] = d;                     // mirror the byte
	endtask

	task automatic host_read(input dbf_pkg::bus_addr_t a, output dbf_pkg::value_t d);
		int lat;
		@(posedge Clk);
		cs_n <= 1'b0;
		rw   <= 1'b0;
		addr <= a;
		wait_ack(lat);
		d = rdata;                                         // valid with ack
		match_latency({test_name, " read ack latency"}, RD_ACK_LAT, lat);
		release_bus();
	endtask

	// --------------------------------------------------
	// key side
	// --------------------------------------------------
	task automatic push_key(input dbf_pkg::key_t k);
		@(posedge Clk);
		key    <= k;
		key_wr <= 1'b1;
		exp_q.push_back(ref_value(k));
	endtask

	task automatic end_keys();
		@(posedge Clk);
		key_wr <= 1'b0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0) begin
			@(negedge Clk);
			cycles++;
			if (cycles > DRAIN_LIMIT) begin
				report_failure($sformatf("%s: %0d lookups never completed",
					test_name, exp_q.size()));
			end
		end
		@(negedge Clk);
	endtask

	// --------------------------------------------------
	// value compare and stall count
	// --------------------------------------------------
	initial begin : compare_values
		dbf_pkg::value_t expv;
		stall_strobes = 0;
		alf_seen      = 1'b0;
		@(posedge Reset_N);
		forever begin
			@(negedge Clk);
			if (value_wr === 1'b1) begin
				if (exp_q.size() == 0) begin
					report_failure("value_wr strobed with no key outstanding");
				end
				expv = exp_q.pop_front();
				check_value({test_name, " lookup value"}, expv, value);
				if (alf_seen) begin
					stall_strobes++;                       // issued before the stall
				end
			end
			if (stall_strobes > 2) begin
				report_failure("more than two values came out after value_alf rose");
			end
			if (value_alf !== 1'b1) begin
				stall_strobes = 0;
			end
			alf_seen = (value_alf === 1'b1);
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_failure("watchdog timeout, the run did not finish in time");
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin : run_tests
		dbf_pkg::bus_addr_t a;
		dbf_pkg::value_t    d;
		dbf_pkg::value_t    rd_byte;
		seed      = 32'h0728_8180;
		Reset_N   = 1'b0;
		key       = '0;
		key_wr    = 1'b0;
		value_alf = 1'b0;
		cs_n      = 1'b1;
		rw        = 1'b0;
		addr      = '0;
		wdata     = '0;
		test_name = "reset";
		repeat (RESET_CYCLES) @(posedge Clk);
		Reset_N <= 1'b1;

		@(negedge Clk);
		check_level("reset ack_n", 1'b1, ack_n);
		check_level("reset value_wr", 1'b0, value_wr);
		check_level("reset key_alf", 1'b0, key_alf);
		check_rdata("reset rdata", '0, rdata);

		test_name = "host_fill";                           // load every table byte
		for (int b = 0; b < dbf_pkg::NUM_BANKS; b++) begin
			for (int i = 0; i < dbf_pkg::BANK_DEPTH; i++) begin
				a = '0;
				a[dbf_pkg::BANK_SEL_LSB +: 2] = 2'(b);
				a[9:0] = 10'(i);
				host_write(a, dbf_pkg::value_t'($random(seed)));
			end
		end

		test_name = "host_random";                         // any select, 3 included
		for (int n = 0; n < NUM_RAND; n++) begin
			a = dbf_pkg::bus_addr_t'($random(seed));
			rand_addr_q.push_back(a);
			host_write(a, dbf_pkg::value_t'($random(seed)));
		end
		foreach (rand_addr_q[n]) begin
			host_read(rand_addr_q[n], rd_byte);
			check_rdata(test_name, model[bank_of(rand_addr_q[n])][rand_addr_q[n][9:0]], rd_byte);
		end

		test_name = "select3_alias";                       // write via 3, read via 0
		a = '0;
		a[dbf_pkg::BANK_SEL_LSB +: 2] = 2'd3;
		a[9:0] = 10'h2a5;
		d = dbf_pkg::value_t'($random(seed));
		host_write(a, d);
		a[dbf_pkg::BANK_SEL_LSB +: 2] = 2'd0;
		host_read(a, rd_byte);
		check_rdata(test_name, d, rd_byte);

		test_name = "key_stream";
		for (int n = 0; n < NUM_STREAM; n++) begin
			push_key(dbf_pkg::key_t'($random(seed)));
		end
		end_keys();
		wait_drain();

		test_name = "value_alf_stall";                     // stall mid-stream, then resume
		for (int n = 0; n < NUM_STALL; n++) begin
			push_key(dbf_pkg::key_t'($random(seed)));
			if (n == 10) begin
				value_alf <= 1'b1;
			end
			if (n == 20) begin
				value_alf <= 1'b0;
			end
		end
		end_keys();
		wait_drain();

		test_name = "key_alf_level";                       // fill FIFO under backpressure
		@(posedge Clk);
		value_alf <= 1'b1;
		for (int n = 0; n < NUM_LEVEL; n++) begin
			push_key(dbf_pkg::key_t'($random(seed)));
		end
		@(negedge Clk);
		check_level("key_alf at 14 keys", 1'b0, key_alf);
		end_keys();
		@(negedge Clk);
		check_level("key_alf at 15 keys", 1'b1, key_alf);
		repeat (5) @(posedge Clk);
		value_alf <= 1'b0;
		wait_drain();
		check_level("key_alf after drain", 1'b0, key_alf);

		$display("Test passed");
		$finish;
	end

endmodule

// ==== build.f ====
rtl/dbf_pkg.sv
rtl/key_fifo.sv
rtl/lookup_engine.sv
rtl/host_bus_ctrl.sv
rtl/hash_bank.sv
rtl/dynamic_bloom_filter.sv
dv/dbf_tb.sv

// ==== Makefile ====
# Verilator build and run of the dynamic bloom filter testbench

VERILATOR ?= verilator
TOP       ?= dbf_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
